//--- src/icache_pkg.sv
/*
  Shared geometry and port types for the two-way instruction cache.
  Addresses are 16-bit physical byte addresses. Fetches must be word aligned.
  A line is four 32-bit words and the memory returns it lowest word first.
  The maintenance view reuses the fetch address word, with bit 0 as the way.
*/
package icache_pkg;

  localparam int ADDR_W         = 16;
  localparam int WAY_NUM        = 2;
  localparam int WAY_W          = 1;
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_OFS_W     = 2;
  localparam int IDX_W          = 4;
  localparam int SET_NUM        = 16;
  localparam int TAG_W          = 8;

  typedef logic [WAY_W-1:0] way_t;
  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [WORDS_PER_LINE-1:0][31:0] line_data_t;

  // ================================================
  // address views
  // ================================================
  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    idx_t                  idx;
    logic [WORD_OFS_W-1:0] word_ofs;
    logic [1:0]            byte_ofs;
  } icache_fetch_addr_t;

  // index-type maintenance picks the way from the low address bit
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    idx_t             idx;
    logic [2:0]       rsvd;
    way_t             way;
  } icache_maint_addr_t;

  typedef union packed {
    icache_fetch_addr_t fetch;
    icache_maint_addr_t maint;
  } icache_addr_u;

  typedef enum logic [1:0] {
    MAINT_IDX_INV = 2'd1,
    MAINT_HIT_INV = 2'd2
  } maint_mode_e;

  // ================================================
  // port bundles
  // ================================================
  typedef struct packed {
    logic         valid;
    icache_addr_u addr;
  } fetch_req_t;

  typedef struct packed {
    logic         valid;
    icache_addr_u addr;
    logic [31:0]  instr;
  } fetch_rsp_t;

  typedef struct packed {
    logic         valid;
    maint_mode_e  mode;
    icache_addr_u addr;
  } maint_req_t;

  typedef struct packed {
    logic              ar_valid;
    logic [ADDR_W-1:0] ar_addr;
  } mem_req_t;

  typedef struct packed {
    logic        r_valid;
    logic        r_last;
    logic [31:0] r_data;
  } mem_rsp_t;

  // whole-line refill write, also sets the valid bit
  typedef struct packed {
    logic             we;
    way_t             way;
    idx_t             idx;
    logic [TAG_W-1:0] tag;
    line_data_t       data;
  } line_wr_t;

  typedef struct packed {
    logic valid_we;
    way_t way;
    idx_t idx;
    logic plru_we;
    way_t plru_val;
  } meta_wr_t;

  typedef struct packed {
    logic [WAY_NUM-1:0][TAG_W-1:0] tag;
    logic [WAY_NUM-1:0]            valid;
    line_data_t [WAY_NUM-1:0]      line;
    way_t                          plru;
  } lookup_rd_t;

endpackage

//--- src/icache_arrays.sv
/*
  Tag, data and valid storage per way, plus one PLRU bit per set.
  Read data is registered from rd_idx_i, and a write to the read index
  in the same cycle shows up in that read (write-first).
  Only valid and PLRU bits are cleared by reset.
*/
module icache_arrays (
  input  logic                   clk,
  input  logic                   rst_n,
  input  icache_pkg::idx_t       rd_idx_i,
  output icache_pkg::lookup_rd_t rd_data_o,
  input  icache_pkg::line_wr_t   line_wr_i,
  input  icache_pkg::meta_wr_t   meta_wr_i
);

  logic [icache_pkg::TAG_W-1:0] tag_mem  [icache_pkg::WAY_NUM][icache_pkg::SET_NUM];
  icache_pkg::line_data_t       data_mem [icache_pkg::WAY_NUM][icache_pkg::SET_NUM];

  logic [icache_pkg::WAY_NUM-1:0][icache_pkg::SET_NUM-1:0] valid_q;
  icache_pkg::way_t [icache_pkg::SET_NUM-1:0]              plru_q;

  // registered read ports
  logic [icache_pkg::WAY_NUM-1:0][icache_pkg::TAG_W-1:0] rd_tag_q;
  icache_pkg::line_data_t [icache_pkg::WAY_NUM-1:0]      rd_line_q;
  logic [icache_pkg::WAY_NUM-1:0]                        rd_valid_q;
  icache_pkg::way_t                                      rd_plru_q;

  logic [icache_pkg::WAY_NUM-1:0] line_sel;
  logic [icache_pkg::WAY_NUM-1:0] clr_sel;

  always_comb begin
    for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
      line_sel[w] = line_wr_i.we && (line_wr_i.way == icache_pkg::way_t'(w));
      clr_sel[w]  = meta_wr_i.valid_we && (meta_wr_i.way == icache_pkg::way_t'(w));
    end
  end

  // tag and line storage
  always_ff @(posedge clk) begin
    for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
      if (line_sel[w]) begin
        tag_mem[w][line_wr_i.idx]  <= line_wr_i.tag;
        data_mem[w][line_wr_i.idx] <= line_wr_i.data;
      end
      if (line_sel[w] && (line_wr_i.idx == rd_idx_i)) begin
        rd_tag_q[w]  <= line_wr_i.tag;
        rd_line_q[w] <= line_wr_i.data;
      end else begin
        rd_tag_q[w]  <= tag_mem[w][rd_idx_i];
        rd_line_q[w] <= data_mem[w][rd_idx_i];
      end
    end
  end

  // valid and plru bits, refill set beats invalidate
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= '0;
      plru_q     <= '0;
      rd_valid_q <= '0;
      rd_plru_q  <= '0;
    end else begin
      for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
        if (line_sel[w]) begin
          valid_q[w][line_wr_i.idx] <= 1'b1;
        end else if (clr_sel[w]) begin
          valid_q[w][meta_wr_i.idx] <= 1'b0;
        end
        if (line_sel[w] && (line_wr_i.idx == rd_idx_i)) begin
          rd_valid_q[w] <= 1'b1;
        end else if (clr_sel[w] && (meta_wr_i.idx == rd_idx_i)) begin
          rd_valid_q[w] <= 1'b0;
        end else begin
          rd_valid_q[w] <= valid_q[w][rd_idx_i];
        end
      end
      if (meta_wr_i.plru_we) begin
        plru_q[meta_wr_i.idx] <= meta_wr_i.plru_val;
      end
      if (meta_wr_i.plru_we && (meta_wr_i.idx == rd_idx_i)) begin
        rd_plru_q <= meta_wr_i.plru_val;
      end else begin
        rd_plru_q <= plru_q[rd_idx_i];
      end
    end
  end

  always_comb begin
    rd_data_o.tag   = rd_tag_q;
    rd_data_o.valid = rd_valid_q;
    rd_data_o.line  = rd_line_q;
    rd_data_o.plru  = rd_plru_q;
  end

endmodule

//--- src/icache_lookup.sv
/*
  Two-stage lookup pipeline. Stage 0 picks maintenance over fetch and
  indexes the arrays. Stage 1 matches tags, answers, and updates PLRU/valid.
  Stage 1 holds on a miss, during refill and under response back-pressure.
  Maintenance always finishes in its stage-1 cycle.
*/
module icache_lookup (
  input  logic                     clk,
  input  logic                     rst_n,
  input  icache_pkg::fetch_req_t   fetch_req_i,
  output logic                     fetch_ready_o,
  output icache_pkg::fetch_rsp_t   fetch_rsp_o,
  input  logic                     fetch_rsp_ready_i,
  input  icache_pkg::maint_req_t   maint_req_i,
  output logic                     maint_ready_o,
  output logic                     maint_done_o,
  output icache_pkg::idx_t         rd_idx_o,
  input  icache_pkg::lookup_rd_t   rd_data_i,
  output icache_pkg::meta_wr_t     meta_wr_o,
  output logic                     miss_o,
  output icache_pkg::icache_addr_u miss_addr_o,
  input  logic                     refill_busy_i
);

  // stage 1 registers
  logic                     s1_valid_q;
  logic                     s1_maint_q;
  icache_pkg::maint_mode_e  s1_mode_q;
  icache_pkg::icache_addr_u s1_addr_q;

  icache_pkg::icache_addr_u in_addr;
  logic                     in_valid;
  logic                     s1_adv;

  logic [icache_pkg::WAY_NUM-1:0] hit_oh;
  icache_pkg::way_t               hit_way;
  logic                           hit;
  logic                           s1_fetch;
  logic                           s1_maint;
  logic                           fetch_hit;
  logic                           fetch_fire;
  logic                           idx_inv;
  logic                           hit_inv;

  // ================================================
  // stage 0
  // ================================================
  assign in_valid = maint_req_i.valid | fetch_req_i.valid;
  assign in_addr  = maint_req_i.valid ? maint_req_i.addr : fetch_req_i.addr;

  // maintenance wins, fetch waits
  assign maint_ready_o = s1_adv;
  assign fetch_ready_o = s1_adv & ~maint_req_i.valid;

  // both address views share the index field
  assign rd_idx_o = s1_adv ? in_addr.fetch.idx : s1_addr_q.fetch.idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s1_maint_q <= 1'b0;
    end else if (s1_adv) begin
      s1_valid_q <= in_valid;
      s1_maint_q <= maint_req_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_adv && in_valid) begin
      s1_addr_q <= in_addr;
      s1_mode_q <= maint_req_i.mode;
    end
  end

  // ================================================
  // stage 1
  // ================================================
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
      hit_oh[w] = rd_data_i.valid[w] && (rd_data_i.tag[w] == s1_addr_q.fetch.tag);
      if (hit_oh[w]) begin
        hit_way = icache_pkg::way_t'(w);
      end
    end
  end

  assign hit      = |hit_oh;
  assign s1_fetch = s1_valid_q & ~s1_maint_q;
  assign s1_maint = s1_valid_q & s1_maint_q;

  assign fetch_hit  = s1_fetch & hit & ~refill_busy_i;
  assign fetch_fire = fetch_hit & fetch_rsp_ready_i;

  // empty stage, finished maintenance or accepted response
  assign s1_adv = ~s1_valid_q | s1_maint | fetch_fire;

  always_comb begin
    fetch_rsp_o.valid = fetch_hit;
    fetch_rsp_o.addr  = s1_addr_q;
    fetch_rsp_o.instr = rd_data_i.line[hit_way][s1_addr_q.fetch.word_ofs];
  end

  // one refill request per miss, refill keeps the address
  assign miss_o      = s1_fetch & ~hit & ~refill_busy_i;
  assign miss_addr_o = s1_addr_q;

  // maintenance
  assign idx_inv = s1_maint && (s1_mode_q == icache_pkg::MAINT_IDX_INV);
  assign hit_inv = s1_maint && (s1_mode_q == icache_pkg::MAINT_HIT_INV);

  assign maint_done_o = s1_maint;

  always_comb begin
    meta_wr_o.valid_we = idx_inv | (hit_inv & hit);
    meta_wr_o.way      = idx_inv ? s1_addr_q.maint.way : hit_way;
    meta_wr_o.idx      = s1_addr_q.fetch.idx;
    // plru names the way not last hit
    meta_wr_o.plru_we  = fetch_fire;
    meta_wr_o.plru_val = (rd_data_i.plru == hit_way) ? ~rd_data_i.plru : rd_data_i.plru;
  end

endmodule

//--- src/icache_refill.sv
/*
  Miss handler. Presents the line-aligned address until ar_ready, then
  takes every beat shown until r_last. No r_ready, so the memory must only
  send beats for an accepted address.
  The line is written into the victim way on the r_last beat.
*/
module icache_refill (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     miss_i,
  input  icache_pkg::icache_addr_u miss_addr_i,
  input  icache_pkg::way_t         victim_way_i,
  output icache_pkg::mem_req_t     mem_req_o,
  input  logic                     mem_ar_ready_i,
  input  icache_pkg::mem_rsp_t     mem_rsp_i,
  output icache_pkg::line_wr_t     line_wr_o,
  output logic                     refill_busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_BEATS
  } refill_state_e;

  refill_state_e                     state_q;
  icache_pkg::icache_addr_u          line_addr_q;
  logic [icache_pkg::WORD_OFS_W-1:0] beat_cnt_q;
  icache_pkg::line_data_t            beat_buf_q;
  logic                              beat;
  logic                              last_beat;

  assign beat      = (state_q == ST_BEATS) && mem_rsp_i.r_valid;
  assign last_beat = beat && mem_rsp_i.r_last;

  // ================================================
  // state machine
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (miss_i) begin
            state_q <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          beat_cnt_q <= '0;
          if (mem_ar_ready_i) begin
            state_q <= ST_BEATS;
          end
        end
        ST_BEATS: begin
          if (beat) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
          end
          if (last_beat) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // line address and beat buffer
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && miss_i) begin
      line_addr_q <= {miss_addr_i.fetch.tag, miss_addr_i.fetch.idx,
                      {icache_pkg::WORD_OFS_W{1'b0}}, 2'b00};
    end
    if (beat) begin
      beat_buf_q[beat_cnt_q] <= mem_rsp_i.r_data;
    end
  end

  // ================================================
  // outputs
  // ================================================
  assign mem_req_o.ar_valid = (state_q == ST_ADDR);
  assign mem_req_o.ar_addr  = line_addr_q;
  assign refill_busy_o      = (state_q != ST_IDLE);

  always_comb begin
    line_wr_o.we  = last_beat;
    line_wr_o.way = victim_way_i;
    line_wr_o.idx = line_addr_q.fetch.idx;
    line_wr_o.tag = line_addr_q.fetch.tag;
    // final word bypasses the buffer
    for (int i = 0; i < icache_pkg::WORDS_PER_LINE; i++) begin
      if (beat_cnt_q == i[icache_pkg::WORD_OFS_W-1:0]) begin
        line_wr_o.data[i] = mem_rsp_i.r_data;
      end else begin
        line_wr_o.data[i] = beat_buf_q[i];
      end
    end
  end

endmodule

//--- src/icache_top.sv
/*
  Two-way set-associative instruction cache, 16 sets of 16-byte lines.
  Hit latency is one cycle. Misses refill a full line over a burst-read bus.
  Maintenance requests take priority over fetches at the pipeline entry.
  Memory must send exactly four beats, r_last on the fourth, after ar_ready.
*/
module icache_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // fetch side
  input  icache_pkg::fetch_req_t fetch_req_i,
  output logic                   fetch_ready_o,
  output icache_pkg::fetch_rsp_t fetch_rsp_o,
  input  logic                   fetch_rsp_ready_i,
  // maintenance side
  input  icache_pkg::maint_req_t maint_req_i,
  output logic                   maint_ready_o,
  output logic                   maint_done_o,
  // memory read bus
  output icache_pkg::mem_req_t   mem_req_o,
  input  logic                   mem_ar_ready_i,
  input  icache_pkg::mem_rsp_t   mem_rsp_i
);

  icache_pkg::idx_t         rd_idx;
  icache_pkg::lookup_rd_t   rd_data;
  icache_pkg::meta_wr_t     meta_wr;
  icache_pkg::line_wr_t     line_wr;
  icache_pkg::icache_addr_u miss_addr;
  logic                     miss;
  logic                     refill_busy;

  icache_lookup u_lookup (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_req_i       (fetch_req_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_rsp_o       (fetch_rsp_o),
    .fetch_rsp_ready_i (fetch_rsp_ready_i),
    .maint_req_i       (maint_req_i),
    .maint_ready_o     (maint_ready_o),
    .maint_done_o      (maint_done_o),
    .rd_idx_o          (rd_idx),
    .rd_data_i         (rd_data),
    .meta_wr_o         (meta_wr),
    .miss_o            (miss),
    .miss_addr_o       (miss_addr),
    .refill_busy_i     (refill_busy)
  );

  icache_arrays u_arrays (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data),
    .line_wr_i (line_wr),
    .meta_wr_i (meta_wr)
  );

  // victim is the plru bit of the set held in stage 1
  icache_refill u_refill (
    .clk            (clk),
    .rst_n          (rst_n),
    .miss_i         (miss),
    .miss_addr_i    (miss_addr),
    .victim_way_i   (rd_data.plru),
    .mem_req_o      (mem_req_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_rsp_i      (mem_rsp_i),
    .line_wr_o      (line_wr),
    .refill_busy_o  (refill_busy)
  );

endmodule

//--- verification/icache_assert.sv
/*
  Protocol assertions for the instruction cache, bound to icache_top.
  All properties are disabled while rst_n is low.
*/
module icache_assert (
  input logic                   clk,
  input logic                   rst_n,
  input icache_pkg::mem_req_t   mem_req_i,
  input logic                   mem_ar_ready_i,
  input icache_pkg::fetch_rsp_t fetch_rsp_i,
  input logic                   fetch_rsp_ready_i,
  input icache_pkg::lookup_rd_t rd_data_i
);

  int fail_cnt = 0;

  // ================================================
  // memory read address channel
  // ================================================
  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i.ar_valid && !mem_ar_ready_i |=>
      mem_req_i.ar_valid && $stable(mem_req_i.ar_addr))
    else begin
      fail_cnt++;
      $error("ar_valid dropped or ar_addr changed before ar_ready");
    end

  // ================================================
  // fetch response and tag match
  // ================================================
  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_rsp_i.valid && !fetch_rsp_ready_i |=>
      fetch_rsp_i.valid && $stable(fetch_rsp_i))
    else begin
      fail_cnt++;
      $error("fetch response changed while stalled by back-pressure");
    end

  // same tag in both ways would give a two-way match
  a_one_way_match: assert property (@(posedge clk) disable iff (!rst_n)
    rd_data_i.valid == 2'b11 |-> rd_data_i.tag[0] != rd_data_i.tag[1])
    else begin
      fail_cnt++;
      $error("both ways of a set hold the same valid tag");
    end

endmodule

//--- verification/tb_icache.sv
/*
  Testbench for the two-way instruction cache. Directed and random
  fetches and maintenance ops are checked against a reference model.
  Memory word at byte address A is {~A, A}. Fetches are word aligned.
  Random stimulus uses a fixed seed, so every run is the same.
*/
module tb_icache;

  localparam int N_DIRECTED = 15;
  localparam int N_RANDOM   = 400;
  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT    = (N_DIRECTED + N_RANDOM) * 60 * CLK_PERIOD;

  logic                   clk;
  logic                   rst_n;
  icache_pkg::fetch_req_t fetch_req_i;
  logic                   fetch_ready_o;
  icache_pkg::fetch_rsp_t fetch_rsp_o;
  logic                   fetch_rsp_ready_i;
  icache_pkg::maint_req_t maint_req_i;
  logic                   maint_ready_o;
  logic                   maint_done_o;
  icache_pkg::mem_req_t   mem_req_o;
  logic                   mem_ar_ready_i;
  icache_pkg::mem_rsp_t   mem_rsp_i;

  int err_cnt      = 0;
  int rsp_cnt      = 0;
  int act_reads    = 0;
  int exp_read_cnt = 0;
  int maint_cnt    = 0;
  int done_cnt     = 0;

  // {addr, instr} in request order, and line addresses of expected reads
  logic [47:0] exp_rsp   [$];
  logic [15:0] exp_reads [$];

  // reference model state
  logic [7:0] m_tag   [icache_pkg::SET_NUM][icache_pkg::WAY_NUM];
  logic       m_valid [icache_pkg::SET_NUM][icache_pkg::WAY_NUM];
  logic       m_plru  [icache_pkg::SET_NUM];

  icache_top u_icache_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_req_i       (fetch_req_i),
    .fetch_ready_o     (fetch_ready_o),
    .fetch_rsp_o       (fetch_rsp_o),
    .fetch_rsp_ready_i (fetch_rsp_ready_i),
    .maint_req_i       (maint_req_i),
    .maint_ready_o     (maint_ready_o),
    .maint_done_o      (maint_done_o),
    .mem_req_o         (mem_req_o),
    .mem_ar_ready_i    (mem_ar_ready_i),
    .mem_rsp_i         (mem_rsp_i)
  );

  bind icache_top icache_assert u_icache_assert (
    .clk               (clk),
    .rst_n             (rst_n),
    .mem_req_i         (mem_req_o),
    .mem_ar_ready_i    (mem_ar_ready_i),
    .fetch_rsp_i       (fetch_rsp_o),
    .fetch_rsp_ready_i (fetch_rsp_ready_i),
    .rd_data_i         (rd_data)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ================================================
  // helpers and reference model
  // ================================================
  function automatic logic [31:0] mem_word(input logic [15:0] addr);
    return {~addr, addr};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp_val);
    err_cnt++;
    $display("error at time %0t: %s got %0h expected %0h", $time, name, got, exp_val);
  endtask

  task automatic print_summary();
    $display("summary: %0d responses, %0d memory reads, %0d maintenance ops, %0d errors",
             rsp_cnt, act_reads, maint_cnt, err_cnt);
  endtask

  // returns 1 when the fetch should hit, victim is the plru way on a miss
  function automatic logic predict_fetch(input logic [15:0] addr);
    logic [3:0] set;
    logic       hit;
    logic       way;
    set = addr[7:4];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
      if (m_valid[set][w] && (m_tag[set][w] == addr[15:8])) begin
        hit = 1'b1;
        way = w[0];
      end
    end
    if (!hit) begin
      way = m_plru[set];
      m_tag[set][way]   = addr[15:8];
      m_valid[set][way] = 1'b1;
      exp_reads.push_back({addr[15:4], 4'h0});
      exp_read_cnt++;
    end
    // plru points away from the way just used
    m_plru[set] = ~way;
    exp_rsp.push_back({addr, mem_word(addr)});
    return hit;
  endfunction

  function automatic void apply_invalidate(input icache_pkg::maint_mode_e mode,
                                           input logic [15:0] addr);
    logic [3:0] set;
    set = addr[7:4];
    if (mode == icache_pkg::MAINT_IDX_INV) begin
      m_valid[set][addr[0]] = 1'b0;
    end else begin
      for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
        if (m_valid[set][w] && (m_tag[set][w] == addr[15:8])) begin
          m_valid[set][w] = 1'b0;
        end
      end
    end
  endfunction

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic fetch_once(input logic [15:0] addr);
    logic hit_exp;
    fetch_req_i = {1'b1, addr};
    // ready is sampled a quarter period after the falling edge
    #(CLK_PERIOD / 4);
    while (!fetch_ready_o) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
    end
    @(posedge clk);
    hit_exp = predict_fetch(addr);
    @(negedge clk);
    fetch_req_i.valid = 1'b0;
    if (hit_exp && (fetch_rsp_o.valid !== 1'b1)) begin
      report_mismatch("fetch_rsp_o.valid", 32'(fetch_rsp_o.valid), 32'h1);
    end
  endtask

  task automatic maintain_line(input icache_pkg::maint_mode_e mode, input logic [15:0] addr);
    maint_req_i = {1'b1, mode, addr};
    #(CLK_PERIOD / 4);
    while (!maint_ready_o) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
    end
    @(posedge clk);
    apply_invalidate(mode, addr);
    maint_cnt++;
    @(negedge clk);
    maint_req_i.valid = 1'b0;
    if (maint_done_o !== 1'b1) begin
      report_mismatch("maint_done_o", 32'(maint_done_o), 32'h1);
    end
  endtask

  // ================================================
  // memory responder and monitors
  // ================================================
  initial begin : mem_responder
    logic [15:0] line_addr;
    logic [15:0] exp_line;
    int unsigned gap;
    mem_ar_ready_i = 1'b0;
    mem_rsp_i      = '0;
    forever begin
      @(negedge clk);
      if (mem_req_o.ar_valid) begin
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge clk);
        mem_ar_ready_i = 1'b1;
        line_addr      = mem_req_o.ar_addr;
        @(negedge clk);
        mem_ar_ready_i = 1'b0;
        act_reads++;
        if (exp_reads.size() == 0) begin
          err_cnt++;
          $display("unexpected memory read of line %h at time %0t", line_addr, $time);
        end else begin
          exp_line = exp_reads.pop_front();
          if (line_addr !== exp_line) begin
            report_mismatch("mem_req_o.ar_addr", 32'(line_addr), 32'(exp_line));
          end
        end
        // four beats, lowest word first, with random gaps
        for (int b = 0; b < icache_pkg::WORDS_PER_LINE; b++) begin
          gap = $urandom_range(0, 2);
          repeat (gap) @(negedge clk);
          mem_rsp_i.r_valid = 1'b1;
          mem_rsp_i.r_last  = (b == icache_pkg::WORDS_PER_LINE - 1);
          mem_rsp_i.r_data  = mem_word(line_addr + 16'(b * 4));
          @(negedge clk);
          mem_rsp_i = '0;
        end
      end
    end
  end

  initial begin : rsp_ready_driver
    fetch_rsp_ready_i = 1'b1;
    forever begin
      @(negedge clk);
      fetch_rsp_ready_i = ($urandom_range(0, 3) != 0);
    end
  end

  // outputs are sampled once they have settled before the rising edge
  initial begin : rsp_monitor
    logic [47:0] exp_item;
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (rst_n && maint_done_o) begin
        done_cnt++;
      end
      if (rst_n && fetch_rsp_o.valid && fetch_rsp_ready_i) begin
        rsp_cnt++;
        if (exp_rsp.size() == 0) begin
          err_cnt++;
          $display("unexpected fetch response at time %0t", $time);
        end else begin
          exp_item = exp_rsp.pop_front();
          if (fetch_rsp_o.addr !== exp_item[47:32]) begin
            report_mismatch("fetch_rsp_o.addr", 32'(fetch_rsp_o.addr), 32'(exp_item[47:32]));
          end
          if (fetch_rsp_o.instr !== exp_item[31:0]) begin
            report_mismatch("fetch_rsp_o.instr", fetch_rsp_o.instr, exp_item[31:0]);
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("timeout: the run did not finish within %0d time units", TIMEOUT);
    print_summary();
    $display("CHECKS FAILED");
    $finish;
  end

  // ================================================
  // main sequence
  // ================================================
  initial begin : main_seq
    logic [7:0] tag;
    logic [3:0] idx;
    logic [1:0] wofs;
    logic       way;
    void'($urandom(67));
    rst_n       = 1'b0;
    fetch_req_i = '0;
    maint_req_i = '0;
    for (int s = 0; s < icache_pkg::SET_NUM; s++) begin
      m_plru[s] = 1'b0;
      for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
        m_valid[s][w] = 1'b0;
      end
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (fetch_rsp_o.valid !== 1'b0) begin
      report_mismatch("fetch_rsp_o.valid", 32'(fetch_rsp_o.valid), 32'h0);
    end
    if (maint_done_o !== 1'b0) begin
      report_mismatch("maint_done_o", 32'(maint_done_o), 32'h0);
    end
    if (mem_req_o.ar_valid !== 1'b0) begin
      report_mismatch("mem_req_o.ar_valid", 32'(mem_req_o.ar_valid), 32'h0);
    end

    // one line, then repeats that hit it
    fetch_once(16'h1230);
    fetch_once(16'h1234);
    fetch_once(16'h123c);
    // three tags into set 3 exercise plru eviction
    fetch_once(16'h1030);
    fetch_once(16'h2030);
    fetch_once(16'h3030);
    fetch_once(16'h2034);
    fetch_once(16'h1030);
    // index invalidate of way 1 only
    maintain_line(icache_pkg::MAINT_IDX_INV, 16'h0031);
    fetch_once(16'h2030);
    fetch_once(16'h1038);
    // hit invalidate of a present line, then of an absent one
    maintain_line(icache_pkg::MAINT_HIT_INV, 16'h1030);
    fetch_once(16'h1030);
    maintain_line(icache_pkg::MAINT_HIT_INV, 16'h7730);
    fetch_once(16'h1034);

    // few tags over few sets keep the hit rate useful
    for (int n = 0; n < N_RANDOM; n++) begin
      tag  = 8'($urandom_range(0, 3));
      idx  = 4'($urandom_range(0, 7));
      wofs = 2'($urandom_range(0, 3));
      way  = 1'($urandom_range(0, 1));
      if ($urandom_range(0, 99) < 85) begin
        fetch_once({tag, idx, wofs, 2'b00});
      end else if ($urandom_range(0, 1) == 0) begin
        maintain_line(icache_pkg::MAINT_IDX_INV, {tag, idx, 3'b000, way});
      end else begin
        maintain_line(icache_pkg::MAINT_HIT_INV, {tag, idx, wofs, 2'b00});
      end
    end

    while (exp_rsp.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(negedge clk);
    if (act_reads != exp_read_cnt) begin
      report_mismatch("memory read count", 32'(act_reads), 32'(exp_read_cnt));
    end
    if (done_cnt != maint_cnt) begin
      report_mismatch("maint_done_o pulse count", 32'(done_cnt), 32'(maint_cnt));
    end
    err_cnt += u_icache_top.u_icache_assert.fail_cnt;

    print_summary();
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
src/icache_pkg.sv
src/icache_arrays.sv
src/icache_lookup.sv
src/icache_refill.sv
src/icache_top.sv
verification/icache_assert.sv
verification/tb_icache.sv

//--- run.sh
#!/bin/bash
# build and run the icache testbench with Verilator
set -e
set -o pipefail

verilator --binary --assert --top-module tb_icache -f sources.f -Mdir obj_dir
./obj_dir/Vtb_icache 2>&1 | tee sim.log

# the testbench prints its fail message on any failed check or timeout
if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
